/* project.f */
+incdir+rtl
rtl/cpuPkg.sv
rtl/instructionSequencer.sv
rtl/jumpGroupDecoder.sv
rtl/programCounter.sv
rtl/linkRegisterFile.sv
rtl/jumpControlTop.sv
sim/jumpControlTb.sv

/* sim/jumpControlTb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpuParams.svh"

module jumpControlTb import cpuPkg::*; ();

	localparam int  NUM_INSTR   = 300;
	localparam time WATCHDOG_NS = 2 * (NUM_INSTR * 4 + 16) * 20;

	logic     CLK;
	logic     RESET;
	word_t    instr;
	word_t    din;
	logic     ccZero;
	logic     ccCarry;
	logic     ccSign;
	logic     ccParity;
	logic     loadEn;
	regAddr_t loadAddr;
	word_t    loadData;
	logic     fetch;
	word_t    pc;
	word_t    addrBus;
	logic     rd;

	// reference model state from the instruction rules.
	word_t  regModel [`CPU_NUM_REGS];
	word_t  modelPc;
	phase_t tbPhase;

	jumpControlTop dut (
		.CLK(CLK), .RESET(RESET), .instr(instr), .din(din),
		.ccZero(ccZero), .ccCarry(ccCarry), .ccSign(ccSign), .ccParity(ccParity),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.fetch(fetch), .pc(pc), .addrBus(addrBus), .rd(rd)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic abortRun(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string sigName, input word_t expected, input word_t actual);
		assert (actual === expected) else
			abortRun($sformatf("[ERROR] t=%0t %s in %s: expected %h, actual %h",
				$time, sigName, tbPhase.name(), expected, actual));
	endtask

	// pc holds in every phase and only moves across COMMIT.
	task automatic checkOutputs(input logic expFetch, input logic expRd,
		input logic busValid, input word_t expBus);
		checkWord("fetch", expFetch, fetch);
		checkWord("rd", expRd, rd);
		checkWord("pc", modelPc, pc);
		if (busValid) begin
			checkWord("addrBus", expBus, addrBus);
		end
	endtask

	function automatic word_t randomEven();
		bit [31:0] r;
		word_t     v;
		r = $urandom;
		v = r[15:0];
		v[0] = 1'b0;
		return v;
	endfunction

	// mostly jump group and the rest spread over the three no-op groups.
	function automatic word_t pickInstr(input logic forceReturn);
		bit [31:0] r;
		word_t     w;
		int        g;
		r = $urandom;
		w = r[15:0];
		if (forceReturn) begin
			w[`CPU_FIELD_GROUP] = `CPU_GROUP_JUMP;
			w[`CPU_FIELD_SKIP]  = `CPU_SKIP_ALWAYS0;
			w[`CPU_FIELD_JP]    = `CPU_JP_ABS_REG;
			w[`CPU_FIELD_LINK]  = 1'b0;
			w[`CPU_FIELD_ARGB]  = `CPU_LINK_REG;
		end else if ($urandom_range(4, 0) != 0) begin
			w[`CPU_FIELD_GROUP] = `CPU_GROUP_JUMP;
		end else begin
			g = $urandom_range(2, 0);
			w[`CPU_FIELD_GROUP] = (g == 2) ? 2'b11 : g[1:0];
		end
		return w;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		#(WATCHDOG_NS);
		abortRun("watchdog expired before all instructions were retired");
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus, memory model and reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		int        rngSeed;
		int        i;
		int        n;
		bit [31:0] r;
		logic [3:0] flags;
		word_t     w;
		word_t     memWord;
		word_t     nextPc;
		word_t     retAddr;
		word_t     rbVal;
		word_t     expBus;
		sel2_t     skip;
		sel2_t     mode;
		logic      isJump;
		logic      cond;
		logic      taken;
		logic      expRd;
		logic      busOn;
		logic      linkIt;
		logic      wantReturn;
		logic      rdSeen;

		rngSeed = 32'hd3b8eaa9;
		void'($urandom(rngSeed));

		RESET    = 1'b1;
		instr    = '0;
		din      = '0;
		ccZero   = 1'b0;
		ccCarry  = 1'b0;
		ccSign   = 1'b0;
		ccParity = 1'b0;
		modelPc    = `CPU_RESET_PC;
		wantReturn = 1'b0;
		tbPhase    = FETCH;

		// the register file is filled through the host port while reset is held.
		regModel[0] = randomEven();
		loadEn   = 1'b1;
		loadAddr = '0;
		loadData = regModel[0];
		for (i = 1; i < `CPU_NUM_REGS; i++) begin
			@(posedge CLK);
			regModel[i] = randomEven();
			loadAddr <= i[3:0];
			loadData <= regModel[i];
		end
		@(posedge CLK);
		loadEn <= 1'b0;
		RESET  <= 1'b0;

		// each pass starts on the edge that opens FETCH.
		// the first pass also covers the state right after reset.
		for (n = 0; n < NUM_INSTR; n++) begin
			w = pickInstr(wantReturn);
			r = $urandom;
			flags = r[3:0];
			memWord = randomEven();
			instr    <= w;
			ccZero   <= flags[0];
			ccCarry  <= flags[1];
			ccSign   <= flags[2];
			ccParity <= flags[3];

			case (w[`CPU_FIELD_CC])
				`CPU_CC_Z: cond = flags[0];
				`CPU_CC_C: cond = flags[1];
				`CPU_CC_S: cond = flags[2];
				default:   cond = flags[3];
			endcase
			skip   = w[`CPU_FIELD_SKIP];
			mode   = w[`CPU_FIELD_JP];
			isJump = (w[`CPU_FIELD_GROUP] == `CPU_GROUP_JUMP);
			taken  = isJump && (!skip[1] || (cond ^ skip[0]));
			rbVal  = regModel[w[`CPU_FIELD_ARGB]];
			retAddr = modelPc + (mode[1] ? 16'd4 : 16'd2);
			expRd  = taken && (mode != `CPU_JP_ABS_REG);
			busOn  = isJump && (mode != `CPU_JP_ABS_REG);
			expBus = (mode == `CPU_JP_IND_REG) ? rbVal : modelPc + 16'd2;
			linkIt = taken && w[`CPU_FIELD_LINK];

			if (!isJump) begin
				nextPc = modelPc + 16'd2;
			end else if (!taken) begin
				nextPc = retAddr;
			end else begin
				case (mode)
					`CPU_JP_ABS_REG:  nextPc = rbVal;
					`CPU_JP_IND_REG:  nextPc = memWord;
					`CPU_JP_ABS_HERE: nextPc = memWord;
					default:          nextPc = modelPc + memWord;
				endcase
			end

			tbPhase = FETCH;
			@(negedge CLK);
			checkOutputs(1'b1, 1'b0, 1'b1, modelPc);

			@(posedge CLK);
			tbPhase = DECODE;
			@(negedge CLK);
			checkOutputs(1'b0, 1'b0, busOn, expBus);

			@(posedge CLK);
			tbPhase = EXECUTE;
			@(negedge CLK);
			checkOutputs(1'b0, expRd, busOn, expBus);
			rdSeen = rd;

			// memory answers a read with its word and otherwise drives unrelated data.
			@(posedge CLK);
			tbPhase = COMMIT;
			din <= rdSeen ? memWord : randomEven();
			@(negedge CLK);
			checkOutputs(1'b0, expRd, busOn, expBus);

			@(posedge CLK);
			modelPc = nextPc;
			if (linkIt) begin
				regModel[`CPU_LINK_REG] = retAddr;
			end
			// a linked jump, taken or not, is followed by a return through R15.
			wantReturn = isJump && w[`CPU_FIELD_LINK];
		end

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/jumpControlTop.sv */
`timescale 1ns/100ps
`default_nettype none

module jumpControlTop import cpuPkg::*; (
	input  wire logic     CLK,
	input  wire logic     RESET,
	input  wire word_t    instr,
	input  wire word_t    din,
	input  wire logic     ccZero,
	input  wire logic     ccCarry,
	input  wire logic     ccSign,
	input  wire logic     ccParity,
	input  wire logic     loadEn,
	input  wire regAddr_t loadAddr,
	input  wire word_t    loadData,
	output logic          fetch,
	output word_t         pc,
	output word_t         addrBus,
	output logic          rd
);

	// phase strobes.
	logic decode;
	logic execute;
	logic commit;

	// latched instruction fields.
	sel2_t    groupF;
	sel2_t    skipF;
	sel2_t    ccF;
	sel2_t    jpF;
	logic     jlF;
	regAddr_t argB;

	// decoder selects.
	sel2_t   pcOffsetSel;
	sel2_t   pcBaseSel;
	sel2_t   addrBusSel;
	sel2_t   retAddrSel;
	sel2_t   regAAddrSel;
	sel2_t   regBAddrSel;
	regSeq_t regSeq;

	word_t regBData;
	word_t retAddr;

	instructionSequencer sequencer (
		.CLK(CLK), .RESET(RESET), .instr(instr),
		.fetch(fetch), .decode(decode), .execute(execute), .commit(commit),
		.groupF(groupF), .skipF(skipF), .ccF(ccF), .jpF(jpF), .jlF(jlF),
		.argB(argB)
	);

	jumpGroupDecoder decoder (
		.CLK(CLK), .RESET(RESET),
		.decode(decode), .execute(execute), .commit(commit),
		.groupF(groupF), .skipF(skipF), .ccF(ccF), .jpF(jpF), .jlF(jlF),
		.ccZero(ccZero), .ccCarry(ccCarry), .ccSign(ccSign), .ccParity(ccParity),
		.pcOffsetSel(pcOffsetSel), .pcBaseSel(pcBaseSel),
		.addrBusSel(addrBusSel), .retAddrSel(retAddrSel),
		.regAAddrSel(regAAddrSel), .regBAddrSel(regBAddrSel),
		.regSeq(regSeq), .rd(rd)
	);

	programCounter pcUnit (
		.CLK(CLK), .RESET(RESET), .fetch(fetch), .commit(commit),
		.pcOffsetSel(pcOffsetSel), .pcBaseSel(pcBaseSel),
		.addrBusSel(addrBusSel), .retAddrSel(retAddrSel),
		.regBData(regBData), .din(din),
		.pc(pc), .addrBus(addrBus), .retAddr(retAddr)
	);

	linkRegisterFile regFile (
		.CLK(CLK), .commit(commit), .regSeq(regSeq),
		.regAAddrSel(regAAddrSel), .regBAddrSel(regBAddrSel),
		.argB(argB), .retAddr(retAddr),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.regBData(regBData)
	);

endmodule

`default_nettype wire

/* rtl/linkRegisterFile.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpuParams.svh"

module linkRegisterFile import cpuPkg::*; (
	input  wire logic     CLK,
	input  wire logic     commit,
	input  wire regSeq_t  regSeq,
	input  wire sel2_t    regAAddrSel,
	input  wire sel2_t    regBAddrSel,
	input  wire regAddr_t argB,
	input  wire word_t    retAddr,
	input  wire logic     loadEn,
	input  wire regAddr_t loadAddr,
	input  wire word_t    loadData,
	output word_t         regBData
);

	word_t    regs [`CPU_NUM_REGS];
	regAddr_t aAddr;
	regAddr_t bAddr;
	logic     linkWrite;

	// port A is the write side, port B the combinational read.
	always_comb begin
		case (regAAddrSel)
			`CPU_REGA_ADDR_ARGB: aAddr = argB;
			default:             aAddr = `CPU_LINK_REG;
		endcase
	end

	always_comb begin
		case (regBAddrSel)
			`CPU_REGB_ADDR_LINK: bAddr = `CPU_LINK_REG;
			default:             bAddr = argB;
		endcase
	end

	assign linkWrite = commit && (regSeq == `CPU_REG_SEQ_LDA_RDB);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write ports
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// host loads work in reset too.
	// the link write comes last so it wins on a shared register.
	always_ff @(posedge CLK) begin
		if (loadEn) begin
			regs[loadAddr] <= loadData;
		end
		if (linkWrite) begin
			regs[aAddr] <= retAddr;
		end
	end

	assign regBData = regs[bAddr];

endmodule

`default_nettype wire

/* rtl/programCounter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpuParams.svh"

module programCounter import cpuPkg::*; (
	input  wire logic  CLK,
	input  wire logic  RESET,
	input  wire logic  fetch,
	input  wire logic  commit,
	input  wire sel2_t pcOffsetSel,
	input  wire sel2_t pcBaseSel,
	input  wire sel2_t addrBusSel,
	input  wire sel2_t retAddrSel,
	input  wire word_t regBData,
	input  wire word_t din,
	output word_t      pc,
	output word_t      addrBus,
	output word_t      retAddr
);

	word_t here2;
	word_t here4;
	word_t base;
	word_t offset;
	word_t pcNext;

	assign here2 = pc + 16'd2;
	assign here4 = pc + 16'd4;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next pc adder
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		case (pcBaseSel)
			`CPU_PC_BASE_PC:   base = pc;
			`CPU_PC_BASE_REGB: base = regBData;
			default:           base = '0;
		endcase
	end

	always_comb begin
		case (pcOffsetSel)
			`CPU_PC_OFFSET_0: offset = '0;
			`CPU_PC_OFFSET_2: offset = 16'd2;
			`CPU_PC_OFFSET_4: offset = 16'd4;
			default:          offset = din;
		endcase
	end

	// relative jumps wrap modulo 64K.
	assign pcNext = base + offset;

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			pc <= `CPU_RESET_PC;
		end else if (commit) begin
			pc <= pcNext;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address bus and return address
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// opcode fetch always uses the pc itself.
	always_comb begin
		if (fetch) begin
			addrBus = pc;
		end else begin
			case (addrBusSel)
				`CPU_ADDR_BUS_HERE: addrBus = here2;
				`CPU_ADDR_BUS_REGB: addrBus = regBData;
				default:            addrBus = pc;
			endcase
		end
	end

	assign retAddr = (retAddrSel == `CPU_RET_ADDR_HERE4) ? here4 : here2;

endmodule

`default_nettype wire

/* rtl/jumpGroupDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpuParams.svh"

module jumpGroupDecoder import cpuPkg::*; (
	input  wire logic  CLK,
	input  wire logic  RESET,
	input  wire logic  decode,
	input  wire logic  execute,
	input  wire logic  commit,
	input  wire sel2_t groupF,
	input  wire sel2_t skipF,
	input  wire sel2_t ccF,
	input  wire sel2_t jpF,
	input  wire logic  jlF,
	input  wire logic  ccZero,
	input  wire logic  ccCarry,
	input  wire logic  ccSign,
	input  wire logic  ccParity,
	output sel2_t      pcOffsetSel,
	output sel2_t      pcBaseSel,
	output sel2_t      addrBusSel,
	output sel2_t      retAddrSel,
	output sel2_t      regAAddrSel,
	output sel2_t      regBAddrSel,
	output regSeq_t    regSeq,
	output logic       rd
);

	logic isJump;
	logic cond;
	logic condOk;
	logic taken;
	logic rdM;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// condition evaluation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign isJump = (groupF == `CPU_GROUP_JUMP);

	always_comb begin
		case (ccF)
			`CPU_CC_Z: cond = ccZero;
			`CPU_CC_C: cond = ccCarry;
			`CPU_CC_S: cond = ccSign;
			default:   cond = ccParity;
		endcase
	end

	// skip codes 00 and 01 ignore the flag altogether.
	always_comb begin
		case (skipF)
			`CPU_SKIP_ALWAYS0: condOk = 1'b1;
			`CPU_SKIP_ALWAYS1: condOk = 1'b1;
			`CPU_SKIP_ONCC:    condOk = cond;
			default:           condOk = ~cond;
		endcase
	end

	assign taken = isJump & condOk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// selector generation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// defaults give a one-word step, PC+2, for anything not a jump.
	always_comb begin
		pcOffsetSel = `CPU_PC_OFFSET_2;
		pcBaseSel   = `CPU_PC_BASE_PC;
		addrBusSel  = `CPU_ADDR_BUS_PC;
		retAddrSel  = `CPU_RET_ADDR_HERE2;
		regAAddrSel = `CPU_REGA_ADDR_LINK;
		regBAddrSel = `CPU_REGB_ADDR_ARGB;
		regSeq      = `CPU_REG_SEQ_NONE;
		rdM         = 1'b0;

		if (isJump) begin
			case (jpF)
				`CPU_JP_ABS_REG: begin
					if (taken) begin
						pcOffsetSel = `CPU_PC_OFFSET_0;
						pcBaseSel   = `CPU_PC_BASE_REGB;
					end
				end

				// target word is fetched from the address held in Rb.
				`CPU_JP_IND_REG: begin
					addrBusSel = `CPU_ADDR_BUS_REGB;
					if (taken) begin
						pcOffsetSel = `CPU_PC_OFFSET_DIN;
						pcBaseSel   = `CPU_PC_BASE_0;
						rdM         = 1'b1;
					end
				end

				// two-word forms, the operand sits right after the opcode.
				`CPU_JP_ABS_HERE: begin
					addrBusSel = `CPU_ADDR_BUS_HERE;
					retAddrSel = `CPU_RET_ADDR_HERE4;
					if (taken) begin
						pcOffsetSel = `CPU_PC_OFFSET_DIN;
						pcBaseSel   = `CPU_PC_BASE_0;
						rdM         = 1'b1;
					end else begin
						pcOffsetSel = `CPU_PC_OFFSET_4;
					end
				end

				default: begin
					addrBusSel = `CPU_ADDR_BUS_HERE;
					retAddrSel = `CPU_RET_ADDR_HERE4;
					if (taken) begin
						pcOffsetSel = `CPU_PC_OFFSET_DIN;
						pcBaseSel   = `CPU_PC_BASE_PC;
						rdM         = 1'b1;
					end else begin
						pcOffsetSel = `CPU_PC_OFFSET_4;
					end
				end
			endcase

			if (taken) begin
				regSeq = jlF ? `CPU_REG_SEQ_LDA_RDB : `CPU_REG_SEQ_RDB;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read strobe
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// high through EXECUTE and COMMIT, dropped as the instruction retires.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			rd <= 1'b0;
		end else if (decode || execute) begin
			rd <= rdM;
		end else if (commit) begin
			rd <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* rtl/instructionSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpuParams.svh"

module instructionSequencer import cpuPkg::*; (
	input  wire logic     CLK,
	input  wire logic     RESET,
	input  wire word_t    instr,
	output logic          fetch,
	output logic          decode,
	output logic          execute,
	output logic          commit,
	output sel2_t         groupF,
	output sel2_t         skipF,
	output sel2_t         ccF,
	output sel2_t         jpF,
	output logic          jlF,
	output regAddr_t      argB
);

	phase_t phase;
	word_t  ir;

	// phase ring, one step per clock and no stalls.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			phase <= FETCH;
		end else begin
			case (phase)
				FETCH:   phase <= DECODE;
				DECODE:  phase <= EXECUTE;
				EXECUTE: phase <= COMMIT;
				default: phase <= FETCH;
			endcase
		end
	end

	// a cleared word decodes as group 00, which is a plain no-op.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			ir <= '0;
		end else if (phase == FETCH) begin
			ir <= instr;
		end
	end

	assign fetch   = (phase == FETCH);
	assign decode  = (phase == DECODE);
	assign execute = (phase == EXECUTE);
	assign commit  = (phase == COMMIT);

	// field split of the held instruction.
	assign groupF = ir[`CPU_FIELD_GROUP];
	assign skipF  = ir[`CPU_FIELD_SKIP];
	assign ccF    = ir[`CPU_FIELD_CC];
	assign jpF    = ir[`CPU_FIELD_JP];
	assign jlF    = ir[`CPU_FIELD_LINK];
	assign argB   = ir[`CPU_FIELD_ARGB];

endmodule

`default_nettype wire

/* rtl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// datapath widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// data word and byte address, both 16 bits.
	typedef logic [15:0] word_t;

	// index into the register file.
	typedef logic [3:0] regAddr_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// two bit multiplexer select, also used for the 2-bit instruction fields.
	typedef logic [1:0] sel2_t;

	// register file access sequence requested by the decoder.
	typedef logic [1:0] regSeq_t;

	// one instruction walks once around this ring.
	typedef enum logic [1:0] {
		FETCH,
		DECODE,
		EXECUTE,
		COMMIT
	} phase_t;

endpackage

`default_nettype wire

/* rtl/cpuParams.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CPU_RESET_PC 16'h0000
`define CPU_LINK_REG 4'd15
`define CPU_NUM_REGS 16
`define CPU_GROUP_JUMP 2'b10

// instruction word fields.
`define CPU_FIELD_GROUP 15:14
`define CPU_FIELD_SKIP 13:12
`define CPU_FIELD_CC 11:10
`define CPU_FIELD_JP 9:8
`define CPU_FIELD_LINK 7
`define CPU_FIELD_ARGB 3:0

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// jump group encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CPU_SKIP_ALWAYS0 2'b00
`define CPU_SKIP_ALWAYS1 2'b01
`define CPU_SKIP_ONCC 2'b10
`define CPU_SKIP_ONNCC 2'b11

`define CPU_CC_Z 2'b00
`define CPU_CC_C 2'b01
`define CPU_CC_S 2'b10
`define CPU_CC_P 2'b11

`define CPU_JP_ABS_REG 2'b00
`define CPU_JP_IND_REG 2'b01
`define CPU_JP_ABS_HERE 2'b10
`define CPU_JP_REL_HERE 2'b11

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath selector codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CPU_PC_OFFSET_0 2'd0
`define CPU_PC_OFFSET_2 2'd1
`define CPU_PC_OFFSET_4 2'd2
`define CPU_PC_OFFSET_DIN 2'd3

`define CPU_PC_BASE_0 2'd0
`define CPU_PC_BASE_PC 2'd1
`define CPU_PC_BASE_REGB 2'd2

`define CPU_ADDR_BUS_PC 2'd0
`define CPU_ADDR_BUS_HERE 2'd1
`define CPU_ADDR_BUS_REGB 2'd2

`define CPU_RET_ADDR_HERE2 2'd0
`define CPU_RET_ADDR_HERE4 2'd1

`define CPU_REGA_ADDR_LINK 2'd0
`define CPU_REGA_ADDR_ARGB 2'd1
`define CPU_REGB_ADDR_ARGB 2'd0
`define CPU_REGB_ADDR_LINK 2'd1

`define CPU_REG_SEQ_NONE 2'd0
`define CPU_REG_SEQ_RDB 2'd1
`define CPU_REG_SEQ_LDA_RDB 2'd2

`endif
